/* verilog/oc_pkg.sv */
package oc_pkg;

	localparam int NUM_BANKS = 4;
	localparam int NUM_REGS = 32;
	localparam int NUM_CU = 2;
	localparam int NUM_SLOTS = NUM_CU * 2;	// two sources per unit
	localparam int OPND_W = 32;
	localparam int IMM_W = 16;
	localparam int BANK_W = $clog2(NUM_BANKS);
	localparam int ROWS = NUM_REGS / NUM_BANKS;	// rows per bank
	localparam int ROW_W = $clog2(ROWS);

	typedef logic [$clog2(NUM_REGS)-1:0] reg_id_t;
	typedef logic [$clog2(NUM_SLOTS)-1:0] slot_id_t;
	typedef logic [$clog2(NUM_CU)-1:0] cu_id_t;
	typedef logic [BANK_W-1:0] bank_id_t;
	typedef logic [ROW_W-1:0] row_id_t;

	typedef struct packed {
		logic [1:0] tag;	// scoreboard id
		logic [3:0] alu_op;
		reg_id_t dst;
		reg_id_t src1;
		reg_id_t src2;
		logic src1_valid;
		logic src2_valid;
		logic [IMM_W-1:0] imm;
		logic imm_valid;	// imm stands in for src2
		logic [7:0] active_mask;
	} instr_t;

	typedef struct packed {
		logic valid;
		reg_id_t rid;
	} rd_req_t;

	typedef struct packed {
		logic valid;
		slot_id_t slot;	// slot that asked for this read
		logic [OPND_W-1:0] data;
	} bk_resp_t;

	typedef struct packed {
		logic valid;
		reg_id_t rid;
		logic [OPND_W-1:0] data;
	} wb_t;

	typedef struct packed {
		instr_t instr;
		logic [OPND_W-1:0] opnd_a;
		logic [OPND_W-1:0] opnd_b;
		cu_id_t cu;
	} exec_t;

	// low bits pick the bank, the rest pick the row
	function automatic bank_id_t bank_of(reg_id_t r);
		return r[BANK_W-1:0];
	endfunction

	function automatic row_id_t row_of(reg_id_t r);
		return r[$bits(reg_id_t)-1:BANK_W];
	endfunction

	function automatic slot_id_t slot_of(cu_id_t cu, logic k);
		return {cu, k};	// unit id times two plus source index
	endfunction

endpackage

/* verilog/reg_bank.sv */
`timescale 1ns/1ps

module reg_bank (
	input logic clk,
	input logic rst,
	input logic rd_en,
	input oc_pkg::row_id_t rd_row,
	output logic [oc_pkg::OPND_W-1:0] rd_data,
	input logic wr_en,
	input oc_pkg::row_id_t wr_row,
	input logic [oc_pkg::OPND_W-1:0] wr_data
);

	import oc_pkg::*;

	logic [OPND_W-1:0] mem [ROWS];

	// write port, rows come up as zero
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < ROWS; i++)
			begin
				mem[i] <= '0;
			end
		end
		else if (wr_en)
		begin
			mem[wr_row] <= wr_data;
		end
	end

	// registered read, same-row write still gives the old value
	always_ff @(posedge clk)
	begin
		if (rd_en)
		begin
			rd_data <= mem[rd_row];
		end
	end

endmodule

/* verilog/bank_arbiter.sv */
`timescale 1ns/1ps

module bank_arbiter (
	input logic clk,
	input logic rst,
	input oc_pkg::rd_req_t req [oc_pkg::NUM_SLOTS],
	output logic [oc_pkg::NUM_SLOTS-1:0] grant,
	input oc_pkg::wb_t wb,
	output oc_pkg::bk_resp_t resp [oc_pkg::NUM_BANKS]
);

	import oc_pkg::*;

	logic [NUM_SLOTS-1:0] hit [NUM_BANKS];	// slots wanting each bank
	logic [NUM_SLOTS-1:0] win [NUM_BANKS];
	logic [NUM_BANKS-1:0] rd_en;
	row_id_t rd_row [NUM_BANKS];
	slot_id_t rd_slot [NUM_BANKS];
	logic [OPND_W-1:0] rd_data [NUM_BANKS];
	logic [NUM_BANKS-1:0] resp_vld;
	slot_id_t resp_slot [NUM_BANKS];

	always_comb
	begin
		grant = '0;
		for (int b = 0; b < NUM_BANKS; b++)
		begin
			for (int s = 0; s < NUM_SLOTS; s++)
			begin
				hit[b][s] = req[s].valid && (bank_of(req[s].rid) == bank_id_t'(b));
			end
			win[b] = hit[b] & (~hit[b] + NUM_SLOTS'(1));	// lowest slot wins
			rd_en[b] = |hit[b];
			rd_row[b] = '0;
			rd_slot[b] = '0;
			for (int s = 0; s < NUM_SLOTS; s++)
			begin
				if (win[b][s])
				begin
					rd_row[b] = row_of(req[s].rid);
					rd_slot[b] = slot_id_t'(s);
				end
			end
			grant = grant | win[b];
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			resp_vld <= '0;
		else
			resp_vld <= rd_en;
	end

	// tag travels alongside the bank read
	always_ff @(posedge clk)
	begin
		for (int b = 0; b < NUM_BANKS; b++)
		begin
			resp_slot[b] <= rd_slot[b];
		end
	end

	for (genvar b = 0; b < NUM_BANKS; b++)
	begin : g_bank
		reg_bank u_bank (
			.clk(clk),
			.rst(rst),
			.rd_en(rd_en[b]),
			.rd_row(rd_row[b]),
			.rd_data(rd_data[b]),
			.wr_en(wb.valid && (bank_of(wb.rid) == bank_id_t'(b))),
			.wr_row(row_of(wb.rid)),
			.wr_data(wb.data)
		);

		assign resp[b] = '{valid: resp_vld[b], slot: resp_slot[b], data: rd_data[b]};

		a_one_grant: assert property (@(posedge clk) disable iff (rst)
			$onehot0(grant & hit[b]));
	end

endmodule

/* verilog/collector_unit.sv */
`timescale 1ns/1ps

module collector_unit #(
	parameter oc_pkg::cu_id_t cu_id = '0
) (
	input logic clk,
	input logic rst,
	input logic alloc,
	input oc_pkg::instr_t instr_in,
	output oc_pkg::rd_req_t req [2],
	input logic [1:0] grant,
	input oc_pkg::bk_resp_t resp [oc_pkg::NUM_BANKS],
	input logic rel,
	output logic busy,
	output logic rdy,
	output oc_pkg::exec_t exec_out
);

	import oc_pkg::*;

	instr_t instr;
	logic [1:0] pend;	// request not granted yet
	logic [1:0] need;	// operand not captured yet
	logic [1:0] need_in;
	logic [1:0] hit;
	logic [OPND_W-1:0] hit_data [2];
	logic [OPND_W-1:0] opnd [2];
	logic [OPND_W-1:0] imm_ext;

	assign need_in[0] = instr_in.src1_valid;
	assign need_in[1] = instr_in.src2_valid && !instr_in.imm_valid;	// imm replaces src2
	assign imm_ext = {{(OPND_W-IMM_W){instr_in.imm[IMM_W-1]}}, instr_in.imm};

	// pick out responses tagged with our slots
	always_comb
	begin
		for (int k = 0; k < 2; k++)
		begin
			hit[k] = 1'b0;
			hit_data[k] = '0;
			for (int b = 0; b < NUM_BANKS; b++)
			begin
				if (resp[b].valid && (resp[b].slot == slot_of(cu_id, k[0])))
				begin
					hit[k] = 1'b1;
					hit_data[k] = resp[b].data;
				end
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			busy <= 1'b0;
			pend <= '0;
			need <= '0;
		end
		else if (alloc)
		begin
			busy <= 1'b1;
			pend <= need_in;
			need <= need_in;
		end
		else if (rel)
		begin
			busy <= 1'b0;
			pend <= '0;
			need <= '0;
		end
		else
		begin
			pend <= pend & ~grant;	// drop request once granted
			need <= need & ~hit;
		end
	end

	always_ff @(posedge clk)
	begin
		if (alloc)
		begin
			instr <= instr_in;
			opnd[0] <= '0;
			opnd[1] <= instr_in.imm_valid ? imm_ext : '0;
		end
		else
		begin
			for (int k = 0; k < 2; k++)
			begin
				if (need[k] && hit[k])
					opnd[k] <= hit_data[k];
			end
		end
	end

	assign req[0] = '{valid: busy && pend[0], rid: instr.src1};
	assign req[1] = '{valid: busy && pend[1], rid: instr.src2};
	assign rdy = busy && (need == '0);
	assign exec_out = '{instr: instr, opnd_a: opnd[0], opnd_b: opnd[1], cu: cu_id};

	a_alloc_free: assert property (@(posedge clk) disable iff (rst)
		alloc |-> !busy);

	// data only shows up for an operand that is still outstanding
	a_resp_expected: assert property (@(posedge clk) disable iff (rst)
		(|hit) |-> busy && ((hit & ~need) == '0) && ((hit & pend) == '0));

endmodule

/* verilog/oc_scheduler.sv */
`timescale 1ns/1ps

module oc_scheduler (
	input logic clk,
	input logic rst,
	input logic issue_valid,
	input logic [oc_pkg::NUM_CU-1:0] busy,
	input logic [oc_pkg::NUM_CU-1:0] rdy,
	output logic issue_ready,
	output logic [oc_pkg::NUM_CU-1:0] alloc,
	output logic [oc_pkg::NUM_CU-1:0] rel,
	output logic exec_valid,
	output oc_pkg::cu_id_t exec_sel
);

	import oc_pkg::*;

	logic [NUM_CU-1:0] older [NUM_CU];	// older[i][j] means i came before j
	logic [NUM_CU-1:0] free;
	logic [NUM_CU-1:0] blocked;

	assign free = ~busy;
	assign issue_ready = |free;
	assign alloc = issue_valid ? (free & (~free + NUM_CU'(1))) : '0;	// lowest free unit

	// oldest ready unit goes to execute
	always_comb
	begin
		rel = '0;
		exec_sel = '0;
		for (int i = 0; i < NUM_CU; i++)
		begin
			blocked[i] = 1'b0;
			for (int j = 0; j < NUM_CU; j++)
			begin
				if (rdy[j] && older[j][i])
					blocked[i] = 1'b1;
			end
			if (rdy[i] && !blocked[i])
			begin
				rel[i] = 1'b1;
				exec_sel = cu_id_t'(i);
			end
		end
	end

	assign exec_valid = |rel;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < NUM_CU; i++)
			begin
				older[i] <= '0;
			end
		end
		else
		begin
			for (int i = 0; i < NUM_CU; i++)
			begin
				if (alloc[i] || rel[i])
					older[i] <= '0;	// newcomer is younger than everyone
				else
					older[i] <= older[i] | alloc;
			end
		end
	end

	a_issue_ready: assert property (@(posedge clk) disable iff (rst)
		issue_valid |-> issue_ready);

	a_release: assert property (@(posedge clk) disable iff (rst)
		$onehot0(rel) && ((rel & ~rdy) == '0));

	// released unit must be free on the next cycle
	a_freed: assert property (@(posedge clk) disable iff (rst)
		(|rel) |=> ((busy & $past(rel)) == '0));

endmodule

/* verilog/operand_collector.sv */
`timescale 1ns/1ps

module operand_collector (
	input logic clk,
	input logic rst,
	input logic issue_valid,
	input oc_pkg::instr_t issue_instr,
	output logic issue_ready,
	input oc_pkg::wb_t wb,
	output logic exec_valid,
	output oc_pkg::exec_t exec
);

	import oc_pkg::*;

	rd_req_t req [NUM_SLOTS];
	logic [NUM_SLOTS-1:0] grant;
	bk_resp_t resp [NUM_BANKS];	// broadcast to every unit
	logic [NUM_CU-1:0] busy;
	logic [NUM_CU-1:0] rdy;
	logic [NUM_CU-1:0] alloc;
	logic [NUM_CU-1:0] rel;
	exec_t cu_exec [NUM_CU];
	cu_id_t exec_sel;

	bank_arbiter u_arb (
		.clk(clk),
		.rst(rst),
		.req(req),
		.grant(grant),
		.wb(wb),
		.resp(resp)
	);

	for (genvar i = 0; i < NUM_CU; i++)
	begin : g_cu
		rd_req_t cu_req [2];
		logic [1:0] cu_grant;

		assign cu_grant[0] = grant[slot_of(cu_id_t'(i), 1'b0)];
		assign cu_grant[1] = grant[slot_of(cu_id_t'(i), 1'b1)];
		assign req[slot_of(cu_id_t'(i), 1'b0)] = cu_req[0];
		assign req[slot_of(cu_id_t'(i), 1'b1)] = cu_req[1];

		collector_unit #(
			.cu_id(cu_id_t'(i))
		) u_cu (
			.clk(clk),
			.rst(rst),
			.alloc(alloc[i]),
			.instr_in(issue_instr),
			.req(cu_req),
			.grant(cu_grant),
			.resp(resp),
			.rel(rel[i]),
			.busy(busy[i]),
			.rdy(rdy[i]),
			.exec_out(cu_exec[i])
		);
	end

	oc_scheduler u_sched (
		.clk(clk),
		.rst(rst),
		.issue_valid(issue_valid),
		.busy(busy),
		.rdy(rdy),
		.issue_ready(issue_ready),
		.alloc(alloc),
		.rel(rel),
		.exec_valid(exec_valid),
		.exec_sel(exec_sel)
	);

	assign exec = cu_exec[exec_sel];	// dispatched unit's bundle

endmodule

/* sim/tb_operand_collector.sv */
`timescale 1ns/1ps

module tb_operand_collector;

	import oc_pkg::*;

	localparam int NUM_ROWS = 8;
	localparam int RESET_CYCLES = 10;
	localparam int TIMEOUT_CYCLES = 40 * NUM_ROWS + NUM_REGS + RESET_CYCLES;

	typedef struct packed {
		instr_t instr;
		wb_t wb;	// write-back applied just before the issue
		logic drain;	// wait until nothing is outstanding
		logic full;	// both units busy right after this issue
	} row_t;

	logic clk;
	logic rst;
	logic issue_valid;
	instr_t issue_instr;
	logic issue_ready;
	wb_t wb;
	logic exec_valid;
	exec_t exec;

	row_t rows [NUM_ROWS];
	string names [NUM_ROWS];
	logic [OPND_W-1:0] model [NUM_REGS];	// reference register file
	logic [31:0] rng;

	// expectations indexed by tag
	instr_t exp_instr [4];
	logic [OPND_W-1:0] exp_a [4];
	logic [OPND_W-1:0] exp_b [4];
	cu_id_t exp_cu [4];
	int exp_row [4];
	logic [3:0] pending;
	int outstanding;
	int cycles;

	logic [NUM_CU-1:0] unit_busy;	// units holding an instruction
	int rel_cycle [NUM_CU];	// cycle of the last dispatch per unit

	operand_collector DUT (
		.clk(clk),
		.rst(rst),
		.issue_valid(issue_valid),
		.issue_instr(issue_instr),
		.issue_ready(issue_ready),
		.wb(wb),
		.exec_valid(exec_valid),
		.exec(exec)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [63:0] exp,
			input logic [63:0] act);
		if (exp !== act)
			fail_run($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
	endtask

	function automatic void set_row(input int i, input string name, input logic [1:0] tag,
			input reg_id_t s1, input logic s1v, input reg_id_t s2, input logic s2v,
			input logic [IMM_W-1:0] imm, input logic immv, input logic drain,
			input logic full);
		rng = lcg_next(rng);
		rows[i] = '0;
		rows[i].instr.tag = tag;
		rows[i].instr.alu_op = 4'(i);
		rows[i].instr.dst = reg_id_t'(NUM_REGS - 1 - i);
		rows[i].instr.src1 = s1;
		rows[i].instr.src1_valid = s1v;
		rows[i].instr.src2 = s2;
		rows[i].instr.src2_valid = s2v;
		rows[i].instr.imm = imm;
		rows[i].instr.imm_valid = immv;
		rows[i].instr.active_mask = rng[23:16];	// arbitrary lane mask
		rows[i].drain = drain;
		rows[i].full = full;
		names[i] = name;
	endfunction

	function automatic void build_table();
		// idx name tag src1 v src2 v imm v drain full
		set_row(0, "diff_banks", 2'd0, 5'd1, 1'b1, 5'd6, 1'b1, 16'h0000, 1'b0, 1'b1, 1'b0);
		set_row(1, "imm_sext", 2'd1, 5'd4, 1'b1, 5'd9, 1'b1, 16'hf00d, 1'b1, 1'b0, 1'b0);
		set_row(2, "bank_conflict", 2'd2, 5'd3, 1'b1, 5'd7, 1'b1, 16'h0000, 1'b0, 1'b0, 1'b0);
		set_row(3, "b2b_first", 2'd3, 5'd10, 1'b1, 5'd13, 1'b1, 16'h0000, 1'b0, 1'b1, 1'b0);
		set_row(4, "b2b_second", 2'd0, 5'd14, 1'b1, 5'd15, 1'b1, 16'h0000, 1'b0, 1'b0, 1'b1);
		set_row(5, "src_invalid", 2'd1, 5'd5, 1'b0, 5'd8, 1'b1, 16'h0000, 1'b0, 1'b0, 1'b0);
		set_row(6, "no_source", 2'd2, 5'd11, 1'b0, 5'd12, 1'b0, 16'h0000, 1'b0, 1'b0, 1'b0);
		set_row(7, "wb_then_read", 2'd3, 5'd20, 1'b1, 5'd2, 1'b1, 16'h0000, 1'b0, 1'b1, 1'b0);
		rows[7].wb = '{valid: 1'b1, rid: 5'd20, data: 32'hcafe_0123};	// overwrite preload
	endfunction

	task automatic preload_regs();
		for (int r = 0; r < NUM_REGS; r++)
		begin
			rng = lcg_next(rng);
			model[r] = rng;
			wb = '{valid: 1'b1, rid: reg_id_t'(r), data: rng};
			@(negedge clk);
		end
		wb = '0;
	endtask

	task automatic issue_row(input int i);
		instr_t ins;
		logic [1:0] t;
		int pick;
		ins = rows[i].instr;
		t = ins.tag;
		if (rows[i].drain)
		begin
			while (outstanding != 0)
				@(negedge clk);
		end
		if (rows[i].wb.valid)
		begin
			wb = rows[i].wb;
			model[rows[i].wb.rid] = rows[i].wb.data;
			@(negedge clk);
			wb = '0;
		end
		while (!issue_ready || pending[t])
			@(negedge clk);
		// a unit dispatching in this cycle is still busy at the alloc edge
		pick = -1;
		for (int u = NUM_CU - 1; u >= 0; u--)
		begin
			if (!unit_busy[u] && rel_cycle[u] != cycles)
				pick = u;	// lowest free unit
		end
		if (pick < 0)
			fail_run("issue_ready was high while every unit still held an instruction");
		exp_cu[t] = cu_id_t'(pick);
		unit_busy[pick] = 1'b1;
		exp_instr[t] = ins;
		exp_a[t] = ins.src1_valid ? model[ins.src1] : '0;
		if (ins.imm_valid)
			exp_b[t] = $signed(ins.imm);	// sign extended
		else
			exp_b[t] = ins.src2_valid ? model[ins.src2] : '0;
		exp_row[t] = i;
		pending[t] = 1'b1;
		outstanding++;
		issue_instr = ins;
		issue_valid = 1'b1;
		@(negedge clk);
		issue_valid = 1'b0;
		if (rows[i].full)
			check_value({names[i], " issue_ready"}, 64'h0, 64'(issue_ready));
	endtask

	task automatic collect_dispatch();
		logic [1:0] t;
		int r;
		t = exec.instr.tag;
		r = exp_row[t];
		if (!pending[t])
			fail_run($sformatf("dispatch with tag %0d but no such instruction outstanding", t));
		else
		begin
			check_value({names[r], " instr"}, 64'(exp_instr[t]), 64'(exec.instr));
			check_value({names[r], " opnd_a"}, 64'(exp_a[t]), 64'(exec.opnd_a));
			check_value({names[r], " opnd_b"}, 64'(exp_b[t]), 64'(exec.opnd_b));
			check_value({names[r], " cu"}, 64'(exp_cu[t]), 64'(exec.cu));
			unit_busy[exp_cu[t]] = 1'b0;
			rel_cycle[exp_cu[t]] = cycles;
			pending[t] = 1'b0;
			outstanding--;
		end
	endtask

	// exec_valid lasts a whole cycle, sampled mid-cycle
	always @(negedge clk)
	begin
		if (!rst && exec_valid)
			collect_dispatch();
	end

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles == TIMEOUT_CYCLES)
			fail_run("timeout: a dispatch never came within the cycle limit");
	end

	initial
	begin
		rst = 1'b1;
		issue_valid = 1'b0;
		issue_instr = '0;
		wb = '0;
		rng = 32'hd2b9;
		pending = '0;
		outstanding = 0;
		cycles = 0;
		unit_busy = '0;
		for (int u = 0; u < NUM_CU; u++)
			rel_cycle[u] = -1;
		build_table();
		repeat (RESET_CYCLES) @(negedge clk);
		rst = 1'b0;
		preload_regs();
		for (int i = 0; i < NUM_ROWS; i++)
			issue_row(i);
		while (outstanding != 0)
			@(negedge clk);
		repeat (10) @(negedge clk);	// catch a late duplicate
		$display("TEST PASSED");
		$finish;
	end

endmodule

/* src.f */
verilog/oc_pkg.sv
verilog/reg_bank.sv
verilog/bank_arbiter.sv
verilog/collector_unit.sv
verilog/oc_scheduler.sv
verilog/operand_collector.sv
sim/tb_operand_collector.sv

/* Makefile */
TOP = tb_operand_collector

.PHONY: help test clean

help:
	@echo "make test    build the testbench with Verilator and run it"
	@echo "make clean   remove the Verilator build directory"
	@echo "make help    show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f src.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
